//--- Makefile
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 -f up_core.f --top-module up_core_tb -o sim
	out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only -Wall --timing -f up_core.f --top-module up_core

clean:
	rm -rf obj_dir

//--- include/up_config.svh
`ifndef UP_CONFIG_SVH
`define UP_CONFIG_SVH

// Data path and register width.
`define UP_DATA_W 8

// Memory address width.
`define UP_ADDR_W 8

// Boot words read straight after reset.
`define UP_BOOT_PC_ADDR 8'hFE
`define UP_BOOT_SP_ADDR 8'hFF

// Fixed interrupt handler entry.
`define UP_IRQ_VECTOR 8'hF0

`endif

//--- up_core.f
+incdir+include
verilog/up_isa_pkg.sv
verilog/up_dp_pkg.sv
verilog/up_regfile.sv
verilog/up_datapath.sv
verilog/up_controller.sv
verilog/up_core.sv
verif/up_core_tb.sv

//--- verif/up_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "up_config.svh"

module up_core_tb;

	localparam logic [7:0] DONE_ADDR = 8'hE0;
	// Worst-case instructions of each test, plus two interrupt entries.
	localparam int LIMIT = (6 + 52 + 28 + 56 + 42) * 5 + 4 * 2 + 200;

	logic clk = 1'b0;
	logic nRst = 1'b0;
	logic irq = 1'b0;
	logic [7:0] mem_rdata = 8'h00;
	wire [7:0] mem_addr;
	wire [7:0] mem_wdata;
	wire ale;
	wire mem_we;

	logic [7:0] mem [256];
	logic [7:0] mmem [256];	// Model copy of the image.
	logic [7:0] addr_q = 8'h00;
	logic [7:0] first_fetch;
	logic [7:0] ppos;
	logic [31:0] got_w [$];	// {cycle, addr, data}.
	logic [31:0] exp_w [$];
	int tcyc;
	int errors = 0;
	int checks = 0;
	int ecyc [4];
	int ne = 0;
	int fetch_cyc [64];
	integer seed;
	bit done_seen;

	// Model state.
	logic [7:0] mr [4];
	logic [7:0] mpc;
	logic [7:0] msp;
	bit mz;
	bit mien;
	bit minsvc;
	bit mpend;
	bit mdone;
	int mep;

	up_core up_core_inst (
		.clk       (clk),
		.nRst      (nRst),
		.irq       (irq),
		.mem_rdata (mem_rdata),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.ale       (ale),
		.mem_we    (mem_we)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	always @(posedge clk or negedge nRst) begin
		if (!nRst) tcyc <= 0;
		else tcyc <= tcyc + 1;	// Cycle 0 is the first cycle out of reset.
	end

	// Outputs are sampled mid-cycle.
	always @(negedge clk) begin
		if (nRst) begin
			if (ale) addr_q = mem_addr;
			if (ale && tcyc == 3) first_fetch = mem_addr;
			if (mem_we) begin
				mem[mem_addr] = mem_wdata;
				got_w.push_back({16'(tcyc), mem_addr, mem_wdata});
				if (mem_addr == DONE_ADDR) done_seen = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		#1;
		mem_rdata = mem[addr_q];
		irq = edge_at(tcyc) || edge_at(tcyc - 1);	// Two-cycle high pulse.
	end

	initial begin
		int wd;
		wd = 0;
		while (wd < LIMIT) begin
			@(posedge clk);
			wd++;
		end
		$display("Timeout: the run went past %0d cycles", LIMIT);
		$display("Finished with errors");
		$finish;
	end

	function automatic bit edge_at(input int c);
		for (int i = 0; i < ne; i++) begin
			if (ecyc[i] == c) return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic logic [7:0] rnd();
		return 8'($random(seed));
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic emit(input logic [7:0] b);
		mem[ppos] = b;
		ppos++;
	endtask

	task automatic ins(input logic [3:0] op, input logic [1:0] rd, input logic [1:0] rs);
		emit({op, rd, rs});
	endtask

	task automatic ldi(input logic [1:0] rd, input logic [7:0] v);
		ins(up_isa_pkg::OP_LDI, rd, 2'd0);
		emit(v);
	endtask

	task automatic st(input logic [1:0] rd, input logic [7:0] a);
		ldi(2'd3, a);	// r3 is the store pointer.
		ins(up_isa_pkg::OP_ST, rd, 2'd3);
	endtask

	task automatic slots(input int n);
		logic [7:0] r;
		for (int i = 0; i < n; i++) begin
			r = rnd();
			if (r % 8'd3 == 8'd0) ldi(r[7:6] % 2'd3, rnd());
			else if (r % 8'd3 == 8'd1) ins({2'b00, r[5:4]}, 2'(rnd() % 8'd3), 2'(rnd() % 8'd3));
			else st(2'(rnd() % 8'd3), 8'h80 | (rnd() & 8'h1F));
		end
	endtask

	task automatic expect_write(input logic [7:0] a, input logic [7:0] d, input int c);
		exp_w.push_back({16'(c), a, d});
		mmem[a] = d;
		if (a == DONE_ADDR) mdone = 1'b1;
	endtask

	// Edges before cycle upto latch a request while enabled.
	task automatic absorb(input int upto);
		while (mep < ne && ecyc[mep] < upto) begin
			if (mien) mpend = 1'b1;
			mep++;
		end
	endtask

	task automatic run_model();
		logic [7:0] ir;
		logic [7:0] a;
		logic [7:0] b;
		int f;
		int n;
		int icnt;
		bit now;
		mmem = mem;
		for (int i = 0; i < 4; i++) mr[i] = 8'h00;
		mpc = mmem[`UP_BOOT_PC_ADDR];
		msp = mmem[`UP_BOOT_SP_ADDR];
		{mz, mien, minsvc, mpend, mdone} = 5'b00000;
		mep = 0;
		f = 3;
		icnt = 0;
		exp_w.delete();
		while (!mdone && icnt < 64) begin
			now = (mep < ne) && (ecyc[mep] == f);
			if (now) mep++;
			if ((mpend || now) && mien && !minsvc) begin
				expect_write(msp, mpc, f + 1);
				msp--;
				mpc = `UP_IRQ_VECTOR;
				minsvc = 1'b1;
				mpend = 1'b0;
				absorb(f + 4);
				f = f + 4;
			end else begin
				if (now && mien) mpend = 1'b1;
				fetch_cyc[icnt] = f;
				icnt++;
				ir = mmem[mpc];
				mpc++;
				a = mr[ir[3:2]];
				b = mr[ir[1:0]];
				n = 3;
				case (ir[7:4])
					up_isa_pkg::OP_ADD, up_isa_pkg::OP_SUB, up_isa_pkg::OP_AND,
					up_isa_pkg::OP_XOR: begin
						case (ir[7:4])
							up_isa_pkg::OP_ADD: a = a + b;
							up_isa_pkg::OP_SUB: a = a - b;
							up_isa_pkg::OP_AND: a = a & b;
							default: a = a ^ b;
						endcase
						mr[ir[3:2]] = a;
						mz = (a == 8'h00);
					end
					up_isa_pkg::OP_LDI: begin
						mr[ir[3:2]] = mmem[mpc];
						mpc++;
						n = 4;
					end
					up_isa_pkg::OP_LD: begin
						mr[ir[3:2]] = mmem[b];
						n = 4;
					end
					up_isa_pkg::OP_ST: expect_write(b, a, f + 2);
					up_isa_pkg::OP_JZ: if (mz) mpc = b;
					up_isa_pkg::OP_JMP: mpc = b;
					up_isa_pkg::OP_PUSH: begin
						expect_write(msp, a, f + 2);
						msp--;
						n = 4;
					end
					up_isa_pkg::OP_POP: begin
						msp++;
						mr[ir[3:2]] = mmem[msp];
						n = 5;
					end
					up_isa_pkg::OP_RETI: begin
						msp++;
						mpc = mmem[msp];
						n = 5;
					end
					default: ;
				endcase
				absorb(f + n);
				if (ir[7:4] == up_isa_pkg::OP_EI) begin
					if (mien) mpend = 1'b0;
					mien = !mien;
				end
				if (ir[7:4] == up_isa_pkg::OP_RETI) minsvc = 1'b0;
				f = f + n;
			end
		end
	endtask

	task automatic run_test(input int t);
		logic [7:0] start_pc;
		logic [7:0] start_sp;
		logic [7:0] va;
		logic [7:0] vb;
		logic [7:0] pt;
		logic [7:0] pj;
		int cnt;
		@(posedge clk);
		#1 nRst = 1'b0;
		repeat (10) @(posedge clk);
		got_w.delete();
		done_seen = 1'b0;
		ne = 0;
		for (int a = 0; a < 256; a++) mem[a] = 8'(a * 37) ^ 8'hC3;
		start_pc = rnd() & 8'h1F;
		start_sp = 8'hC0 | (rnd() & 8'h1F);
		mem[`UP_BOOT_PC_ADDR] = start_pc;
		mem[`UP_BOOT_SP_ADDR] = start_sp;
		ppos = `UP_IRQ_VECTOR;
		ins(up_isa_pkg::OP_PUSH, 2'd0, 2'd0);
		ldi(2'd0, 8'hA8);
		ins(up_isa_pkg::OP_ST, 2'd0, 2'd0);	// Marker byte at its own address.
		ins(up_isa_pkg::OP_POP, 2'd0, 2'd0);
		ins(up_isa_pkg::OP_RETI, 2'd0, 2'd0);
		ppos = start_pc;
		if (t == 1) begin
			ldi(2'd0, rnd());
			ins(up_isa_pkg::OP_PUSH, 2'd0, 2'd0);
		end else if (t == 2) begin
			slots(24);
		end else if (t == 3) begin
			for (int i = 0; i < 4; i++) begin
				ldi(2'd3, 8'h80 | (rnd() & 8'h3F));
				ins(up_isa_pkg::OP_LD, 2'(i % 3), 2'd3);
				ins(up_isa_pkg::OP_PUSH, 2'(i % 3), 2'd0);
			end
			for (int i = 0; i < 4; i++) ins(up_isa_pkg::OP_POP, 2'(rnd() % 8'd3), 2'd0);
			for (int i = 0; i < 4; i++) st(2'(i % 3), 8'(8'hA0 + i));
		end else if (t == 4) begin
			for (int i = 0; i < 4; i++) begin
				va = rnd();
				vb = rnd();
				if (vb[0]) vb = va;	// Roughly half the rounds branch.
				ldi(2'd0, va);
				ldi(2'd1, vb);
				ins(up_isa_pkg::OP_SUB, 2'd0, 2'd1);
				ldi(2'd2, 8'h00);
				pt = ppos - 8'd1;
				ins(up_isa_pkg::OP_JZ, 2'd0, 2'd2);
				ldi(2'd1, 8'(8'h11 + i));
				st(2'd1, 8'(8'h90 + 2 * i));
				ldi(2'd2, 8'h00);
				pj = ppos - 8'd1;
				ins(up_isa_pkg::OP_JMP, 2'd0, 2'd2);
				mem[pt] = ppos;
				ldi(2'd1, 8'(8'h55 + i));
				st(2'd1, 8'(8'h91 + 2 * i));
				mem[pj] = ppos;
			end
		end else begin
			for (int i = 0; i < 3; i++) ins(up_isa_pkg::OP_NOP, 2'd0, 2'd0);
			ins(up_isa_pkg::OP_EI, 2'd0, 2'd0);
			slots(12);
		end
		st(2'd0, DONE_ADDR);
		ldi(2'd2, ppos + 8'd2);
		ins(up_isa_pkg::OP_JMP, 2'd0, 2'd2);	// Park in a self loop.
		run_model();
		if (t == 5) begin
			ecyc[0] = fetch_cyc[1];	// Still disabled here.
			ecyc[1] = fetch_cyc[6];
			ecyc[2] = ecyc[1] + 6;	// Lands inside the handler.
			ne = 3;
			run_model();
		end
		#1 nRst = 1'b1;
		while (!done_seen) @(posedge clk);
		check(32'(got_w.size()), 32'(exp_w.size()), $sformatf("test %0d write count", t));
		foreach (exp_w[i]) begin
			if (i < got_w.size()) begin
				check(got_w[i], exp_w[i], $sformatf("test %0d write %0d {cycle,addr,data}", t, i));
			end
		end
		if (t == 1) begin
			check(32'(first_fetch), 32'(start_pc), "first fetch address");
			check(32'(got_w[0][15:8]), 32'(start_sp), "first push address");
		end
		if (t == 5) begin
			cnt = 0;
			foreach (got_w[i]) if (got_w[i][15:8] == 8'hA8) cnt++;
			check(32'(cnt), 32'd2, "handler runs");
		end
	endtask

	initial begin
		seed = 32'h2b1c_6c17;
		for (int t = 1; t <= 5; t++) run_test(t);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) $display("Finished with no errors");
		else $display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/up_controller.sv
`timescale 1ns/1ps
`default_nettype none

module up_controller (
	input  wire                 clk,
	input  wire                 nRst,
	input  wire                 irq,
	input  wire up_isa_pkg::opcode_e opcode,
	input  wire                 zero,
	output up_dp_pkg::dp_op_e   dp_op
);

	up_isa_pkg::state_e state;
	up_isa_pkg::state_e state_nxt;

	logic int_en;
	logic in_service;
	logic irq_last;
	logic irq_pending;
	logic irq_edge;
	logic int_go;

	assign irq_edge = irq & ~irq_last;

	// A request can be taken from a fresh edge or one held over.
	assign int_go = (irq_pending | irq_edge) & int_en & ~in_service;

	always_comb begin
		state_nxt = state;
		dp_op     = up_dp_pkg::DP_NONE;
		case (state)
			up_isa_pkg::BOOT_PC_ADDR: begin
				dp_op     = up_dp_pkg::DP_ADDR_BOOT_PC;
				state_nxt = up_isa_pkg::BOOT_PC_LOAD;
			end
			up_isa_pkg::BOOT_PC_LOAD: begin
				dp_op     = up_dp_pkg::DP_LOAD_PC_MEM;
				state_nxt = up_isa_pkg::BOOT_SP_LOAD;
			end
			up_isa_pkg::BOOT_SP_LOAD: begin
				dp_op     = up_dp_pkg::DP_LOAD_SP_MEM;
				state_nxt = up_isa_pkg::FETCH;
			end
			up_isa_pkg::FETCH: begin
				dp_op = up_dp_pkg::DP_ADDR_PC;
				if (int_go) begin
					state_nxt = up_isa_pkg::INT_1;	// Fetched byte is dropped.
				end else begin
					state_nxt = up_isa_pkg::DECODE;
				end
			end
			up_isa_pkg::DECODE: begin
				dp_op     = up_dp_pkg::DP_LATCH_IR;
				state_nxt = up_isa_pkg::EXEC_1;
			end
			up_isa_pkg::EXEC_1: begin
				state_nxt = up_isa_pkg::FETCH;
				case (opcode)
					up_isa_pkg::OP_ADD,
					up_isa_pkg::OP_SUB,
					up_isa_pkg::OP_AND,
					up_isa_pkg::OP_XOR: dp_op = up_dp_pkg::DP_ALU;
					up_isa_pkg::OP_LDI: begin
						dp_op     = up_dp_pkg::DP_ADDR_PC;	// Operand byte.
						state_nxt = up_isa_pkg::EXEC_2;
					end
					up_isa_pkg::OP_LD: begin
						dp_op     = up_dp_pkg::DP_ADDR_RS;
						state_nxt = up_isa_pkg::EXEC_2;
					end
					up_isa_pkg::OP_ST: dp_op = up_dp_pkg::DP_STORE_RD;
					up_isa_pkg::OP_JZ: begin
						if (zero) begin
							dp_op = up_dp_pkg::DP_PC_FROM_RS;
						end
					end
					up_isa_pkg::OP_JMP: dp_op = up_dp_pkg::DP_PC_FROM_RS;
					up_isa_pkg::OP_PUSH: begin
						dp_op     = up_dp_pkg::DP_STORE_RD;
						state_nxt = up_isa_pkg::EXEC_2;
					end
					up_isa_pkg::OP_POP,
					up_isa_pkg::OP_RETI: begin
						dp_op     = up_dp_pkg::DP_SP_INC;
						state_nxt = up_isa_pkg::EXEC_2;
					end
					default: dp_op = up_dp_pkg::DP_NONE;	// NOP and EI.
				endcase
			end
			up_isa_pkg::EXEC_2: begin
				state_nxt = up_isa_pkg::FETCH;
				case (opcode)
					up_isa_pkg::OP_LDI: dp_op = up_dp_pkg::DP_LOAD_RD_MEM_INC;
					up_isa_pkg::OP_LD: dp_op = up_dp_pkg::DP_LOAD_RD_MEM;
					up_isa_pkg::OP_PUSH: dp_op = up_dp_pkg::DP_SP_DEC;
					up_isa_pkg::OP_POP,
					up_isa_pkg::OP_RETI: begin
						dp_op     = up_dp_pkg::DP_ADDR_SP;
						state_nxt = up_isa_pkg::EXEC_3;
					end
					default: dp_op = up_dp_pkg::DP_NONE;
				endcase
			end
			up_isa_pkg::EXEC_3: begin
				state_nxt = up_isa_pkg::FETCH;
				if (opcode == up_isa_pkg::OP_RETI) begin
					dp_op = up_dp_pkg::DP_RETURN;
				end else begin
					dp_op = up_dp_pkg::DP_LOAD_RD_MEM;	// POP.
				end
			end
			up_isa_pkg::INT_1: begin
				dp_op     = up_dp_pkg::DP_STORE_PC;	// Push return address.
				state_nxt = up_isa_pkg::INT_2;
			end
			up_isa_pkg::INT_2: begin
				dp_op     = up_dp_pkg::DP_SP_DEC;
				state_nxt = up_isa_pkg::INT_3;
			end
			up_isa_pkg::INT_3: begin
				dp_op     = up_dp_pkg::DP_PC_VECTOR;
				state_nxt = up_isa_pkg::FETCH;
			end
			default: state_nxt = up_isa_pkg::BOOT_PC_ADDR;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state       <= up_isa_pkg::BOOT_PC_ADDR;
			int_en      <= 1'b0;
			in_service  <= 1'b0;
			irq_last    <= 1'b0;
			irq_pending <= 1'b0;
		end else begin
			state    <= state_nxt;
			irq_last <= irq;

			// Edges only count while enabled; held until a FETCH can take them.
			if (state == up_isa_pkg::FETCH && int_go) begin
				in_service  <= 1'b1;
				irq_pending <= 1'b0;
			end else if (irq_edge && int_en) begin
				irq_pending <= 1'b1;
			end

			if (state == up_isa_pkg::EXEC_1) begin
				if (opcode == up_isa_pkg::OP_RETI) begin
					in_service <= 1'b0;
				end
				if (opcode == up_isa_pkg::OP_EI) begin
					int_en <= ~int_en;
					if (int_en) begin
						irq_pending <= 1'b0;	// Disabling drops a held request.
					end
				end
			end
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (!nRst)
		state inside {up_isa_pkg::BOOT_PC_ADDR, up_isa_pkg::BOOT_PC_LOAD,
			up_isa_pkg::BOOT_SP_LOAD, up_isa_pkg::FETCH, up_isa_pkg::DECODE,
			up_isa_pkg::EXEC_1, up_isa_pkg::EXEC_2, up_isa_pkg::EXEC_3,
			up_isa_pkg::INT_1, up_isa_pkg::INT_2, up_isa_pkg::INT_3});

	// No nesting: a held request waits for RETI.
	a_no_nested_int: assert property (@(posedge clk) disable iff (!nRst)
		(state == up_isa_pkg::FETCH && irq_pending && in_service)
		|=> (state != up_isa_pkg::INT_1));

endmodule

`default_nettype wire

//--- verilog/up_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "up_config.svh"

module up_core (
	input  wire                   clk,
	input  wire                   nRst,
	input  wire                   irq,
	input  wire [`UP_DATA_W-1:0]  mem_rdata,
	output logic [`UP_ADDR_W-1:0] mem_addr,
	output logic [`UP_DATA_W-1:0] mem_wdata,
	output logic                  ale,
	output logic                  mem_we
);

	up_dp_pkg::dp_op_e     dp_op;
	up_isa_pkg::opcode_e   opcode;
	logic                  zero;
	logic [1:0]            rd_idx;
	logic [1:0]            rs_idx;
	logic                  rf_we;
	logic [`UP_DATA_W-1:0] rf_wdata;
	logic [`UP_DATA_W-1:0] rd_data;
	logic [`UP_DATA_W-1:0] rs_data;

	up_controller up_controller_inst (
		.clk    (clk),
		.nRst   (nRst),
		.irq    (irq),
		.opcode (opcode),
		.zero   (zero),
		.dp_op  (dp_op)
	);

	up_datapath up_datapath_inst (
		.clk       (clk),
		.nRst      (nRst),
		.dp_op     (dp_op),
		.mem_rdata (mem_rdata),
		.rd_data   (rd_data),
		.rs_data   (rs_data),
		.opcode    (opcode),
		.zero      (zero),
		.rd_idx    (rd_idx),
		.rs_idx    (rs_idx),
		.rf_we     (rf_we),
		.rf_wdata  (rf_wdata),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.ale       (ale),
		.mem_we    (mem_we)
	);

	up_regfile up_regfile_inst (
		.clk     (clk),
		.nRst    (nRst),
		.rd_idx  (rd_idx),
		.rs_idx  (rs_idx),
		.we      (rf_we),
		.wdata   (rf_wdata),
		.rd_data (rd_data),
		.rs_data (rs_data)
	);

endmodule

`default_nettype wire

//--- verilog/up_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "up_config.svh"

module up_datapath (
	input  wire                    clk,
	input  wire                    nRst,
	input  wire up_dp_pkg::dp_op_e dp_op,
	input  wire [`UP_DATA_W-1:0]   mem_rdata,
	input  wire [`UP_DATA_W-1:0]   rd_data,
	input  wire [`UP_DATA_W-1:0]   rs_data,
	output up_isa_pkg::opcode_e    opcode,
	output logic                   zero,
	output logic [1:0]             rd_idx,
	output logic [1:0]             rs_idx,
	output logic                   rf_we,
	output logic [`UP_DATA_W-1:0]  rf_wdata,
	output logic [`UP_ADDR_W-1:0]  mem_addr,
	output logic [`UP_DATA_W-1:0]  mem_wdata,
	output logic                   ale,
	output logic                   mem_we
);

	logic [`UP_ADDR_W-1:0] pc;
	logic [`UP_ADDR_W-1:0] sp;
	logic [`UP_DATA_W-1:0] ir;
	logic [`UP_DATA_W-1:0] alu_y;
	up_dp_pkg::alu_fn_e    alu_fn;

	assign opcode = up_isa_pkg::opcode_e'(ir[7:4]);
	assign rd_idx = ir[3:2];
	assign rs_idx = ir[1:0];
	assign alu_fn = up_dp_pkg::alu_fn_e'(ir[5:4]);

	always_comb begin
		case (alu_fn)
			up_dp_pkg::ALU_ADD: alu_y = rd_data + rs_data;
			up_dp_pkg::ALU_SUB: alu_y = rd_data - rs_data;
			up_dp_pkg::ALU_AND: alu_y = rd_data & rs_data;
			up_dp_pkg::ALU_XOR: alu_y = rd_data ^ rs_data;
		endcase
	end

	// Address, strobes and register bank write.
	always_comb begin
		mem_addr  = pc;
		mem_wdata = rd_data;
		ale       = 1'b0;
		mem_we    = 1'b0;
		rf_we     = 1'b0;
		rf_wdata  = alu_y;
		case (dp_op)
			up_dp_pkg::DP_ADDR_BOOT_PC: begin
				mem_addr = `UP_BOOT_PC_ADDR;
				ale      = 1'b1;
			end
			up_dp_pkg::DP_ADDR_BOOT_SP,
			up_dp_pkg::DP_LOAD_PC_MEM: begin
				mem_addr = `UP_BOOT_SP_ADDR;
				ale      = 1'b1;
			end
			up_dp_pkg::DP_ADDR_PC: ale = 1'b1;
			up_dp_pkg::DP_ADDR_RS: begin
				mem_addr = rs_data;
				ale      = 1'b1;
			end
			up_dp_pkg::DP_ADDR_SP: begin
				mem_addr = sp;
				ale      = 1'b1;
			end
			up_dp_pkg::DP_ALU: rf_we = 1'b1;
			up_dp_pkg::DP_LOAD_RD_MEM,
			up_dp_pkg::DP_LOAD_RD_MEM_INC: begin
				rf_we    = 1'b1;
				rf_wdata = mem_rdata;
			end
			up_dp_pkg::DP_STORE_RD: begin
				// PUSH stores at sp, ST at the address in rs.
				mem_addr = (opcode == up_isa_pkg::OP_PUSH) ? sp : rs_data;
				mem_we   = 1'b1;
			end
			up_dp_pkg::DP_STORE_PC: begin
				mem_addr  = sp;
				mem_wdata = pc;
				mem_we    = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc   <= '0;
			sp   <= '0;
			ir   <= '0;
			zero <= 1'b0;
		end else begin
			case (dp_op)
				up_dp_pkg::DP_LOAD_PC_MEM,
				up_dp_pkg::DP_RETURN: pc <= mem_rdata;
				up_dp_pkg::DP_LOAD_SP_MEM: sp <= mem_rdata;
				up_dp_pkg::DP_LATCH_IR: begin
					ir <= mem_rdata;
					pc <= pc + 1'b1;
				end
				up_dp_pkg::DP_ALU: zero <= (alu_y == '0);
				up_dp_pkg::DP_LOAD_RD_MEM_INC: pc <= pc + 1'b1;	// Skip LDI operand.
				up_dp_pkg::DP_PC_FROM_RS: pc <= rs_data;
				up_dp_pkg::DP_SP_INC: sp <= sp + 1'b1;
				up_dp_pkg::DP_SP_DEC: sp <= sp - 1'b1;
				up_dp_pkg::DP_PC_VECTOR: pc <= `UP_IRQ_VECTOR;
				default: ;
			endcase
		end
	end

	a_strobe_excl: assert property (@(posedge clk) disable iff (!nRst)
		!(ale && mem_we));

endmodule

`default_nettype wire

//--- verilog/up_dp_pkg.sv
`default_nettype none

package up_dp_pkg;

	// Micro-operation sent from the controller each cycle.
	typedef enum logic [4:0] {
		DP_NONE,
		DP_ADDR_BOOT_PC,
		DP_ADDR_BOOT_SP,
		DP_ADDR_PC,
		DP_ADDR_RS,
		DP_ADDR_SP,
		DP_LOAD_PC_MEM,	// Also addresses the boot sp word.
		DP_LOAD_SP_MEM,
		DP_LATCH_IR,
		DP_ALU,
		DP_LOAD_RD_MEM,
		DP_LOAD_RD_MEM_INC,
		DP_PC_FROM_RS,
		DP_STORE_RD,
		DP_STORE_PC,
		DP_SP_INC,
		DP_SP_DEC,
		DP_PC_VECTOR,
		DP_RETURN
	} dp_op_e;

	// Matches the low two opcode bits of the ALU instructions.
	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_AND = 2'd2,
		ALU_XOR = 2'd3
	} alu_fn_e;

endpackage

`default_nettype wire

//--- verilog/up_isa_pkg.sv
`default_nettype none

package up_isa_pkg;

	// Opcode field, instruction bits 7:4.
	typedef enum logic [3:0] {
		OP_ADD   = 4'h0,
		OP_SUB   = 4'h1,
		OP_AND   = 4'h2,
		OP_XOR   = 4'h3,
		OP_LDI   = 4'h4,	// Operand byte follows.
		OP_LD    = 4'h5,
		OP_ST    = 4'h6,
		OP_JZ    = 4'h7,
		OP_JMP   = 4'h8,
		OP_PUSH  = 4'h9,
		OP_POP   = 4'hA,
		OP_RETI  = 4'hB,
		OP_NOP   = 4'hC,
		OP_NOP_D = 4'hD,
		OP_NOP_E = 4'hE,
		OP_EI    = 4'hF	// Toggles the interrupt enable.
	} opcode_e;

	// Controller sequence, one clock per state.
	typedef enum logic [3:0] {
		BOOT_PC_ADDR = 4'h0,
		BOOT_PC_LOAD = 4'h1,
		BOOT_SP_LOAD = 4'h2,
		FETCH        = 4'h3,
		DECODE       = 4'h4,
		EXEC_1       = 4'h5,
		EXEC_2       = 4'h6,
		EXEC_3       = 4'h7,
		INT_1        = 4'h8,
		INT_2        = 4'h9,
		INT_3        = 4'hA
	} state_e;

endpackage

`default_nettype wire

//--- verilog/up_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "up_config.svh"

module up_regfile (
	input  wire                   clk,
	input  wire                   nRst,
	input  wire [1:0]             rd_idx,
	input  wire [1:0]             rs_idx,
	input  wire                   we,
	input  wire [`UP_DATA_W-1:0]  wdata,
	output logic [`UP_DATA_W-1:0] rd_data,
	output logic [`UP_DATA_W-1:0] rs_data
);

	logic [`UP_DATA_W-1:0] regs [4];	// r0 to r3.

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rd_idx] <= wdata;
		end
	end

	// Both read ports are combinational.
	assign rd_data = regs[rd_idx];
	assign rs_data = regs[rs_idx];

	a_we_idx_known: assert property (@(posedge clk) disable iff (!nRst)
		we |-> !$isunknown(rd_idx));

endmodule

`default_nettype wire
